// File: verilog/i2c_defs.svh
// bus and system clock frequencies and the default queue depth.
`ifndef I2C_DEFS_SVH
`define I2C_DEFS_SVH

// system clock in Hz.
`define I2C_CLK_FREQ 50_000_000

// bus clock in Hz, a half period is ten system cycles.
`define I2C_BUS_FREQ 2_500_000

// entries in the command and response queues.
`define I2C_QUEUE_DEPTH 4

`endif

// File: verilog/i2c_bus_pkg.sv
// bus frame types, operation encoding and frame slot positions.
package i2c_bus_pkg;

	typedef enum logic {
		I2C_WR = 1'b0,
		I2C_RD = 1'b1
	} i2c_op_e;

	typedef logic [5:0] slot_t;

	// slots are counted in bus clock rises from the start of a transfer.
	localparam slot_t START_SLOT        = 6'd1;
	localparam slot_t ADDR_ACK_SLOT     = 6'd10;
	localparam slot_t SUB_ACK_SLOT      = 6'd19;
	localparam slot_t RD_REPSTART_SLOT  = 6'd20;
	localparam slot_t WR_DATA_ACK_SLOT  = 6'd28;
	localparam slot_t WR_STOP_SLOT      = 6'd29;
	localparam slot_t RD_ADDR_ACK_SLOT  = 6'd30;
	localparam slot_t RD_DATA_FIRST     = 6'd31;
	localparam slot_t RD_STOP_SLOT      = 6'd40;
	localparam slot_t WR_FRAME_LAST     = 6'd32;
	localparam slot_t RD_FRAME_LAST     = 6'd42;

endpackage

// File: verilog/i2c_req_pkg.sv
// host command and response structures.
package i2c_req_pkg;

	// one register access as pushed by the host.
	typedef struct packed {
		i2c_bus_pkg::i2c_op_e op;
		logic [6:0]           addr;
		logic [7:0]           subaddr;
		logic [7:0]           wdata;
	} i2c_cmd_t;

	// result of one finished transfer.
	typedef struct packed {
		logic [7:0] rdata;
		logic       ack;
	} i2c_rsp_t;

endpackage

// File: verilog/i2c_xfer_if.sv
// transfer interface between the dispatcher and the bit sequencer.
interface i2c_xfer_if;

	// one-cycle request, only while busy is low.
	logic                  start;
	i2c_req_pkg::i2c_cmd_t cmd;

	// rsp holds from the fall of busy until the next start.
	logic                  busy;
	i2c_req_pkg::i2c_rsp_t rsp;

	modport ctrl (
		output start,
		output cmd,
		input  busy,
		input  rsp
	);

	modport seq (
		input  start,
		input  cmd,
		output busy,
		output rsp
	);

endinterface

// File: verilog/i2c_clock_gen.sv
// fractional divider making the bus clock level and its edge pulses.
`include "i2c_defs.svh"

module i2c_clock_gen (
	input  logic CLK,
	input  logic rst_n,
	output logic bus_clk,
	output logic bus_rise,
	output logic bus_fall
);
	localparam logic [31:0] CLK_FREQ    = `I2C_CLK_FREQ;
	localparam logic [31:0] BUS_FREQ_X2 = `I2C_BUS_FREQ * 2;

	logic [31:0] acc;
	logic [31:0] acc_next;
	logic        bus_clk_q;

	assign acc_next = acc + BUS_FREQ_X2;

	// each wrap of the accumulator is half a bus period.
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			acc       <= '0;
			bus_clk   <= 1'b0;
			bus_clk_q <= 1'b0;
		end else begin
			bus_clk_q <= bus_clk;
			if (acc_next >= CLK_FREQ) begin
				acc     <= acc_next - CLK_FREQ;
				bus_clk <= ~bus_clk;
			end else begin
				acc <= acc_next;
			end
		end
	end

	assign bus_rise = bus_clk & ~bus_clk_q;
	assign bus_fall = ~bus_clk & bus_clk_q;

endmodule

// File: verilog/i2c_master.sv
// bit sequencer shifting one register transfer frame onto SCL and SDA.
module i2c_master (
	input  logic    CLK,
	input  logic    rst_n,
	input  logic    bus_clk,
	input  logic    bus_rise,
	input  logic    bus_fall,
	i2c_xfer_if.seq xfer,
	output logic    scl_oe,
	output logic    sda_oe,
	input  logic    scl_in,
	input  logic    sda_in
);
	localparam int unsigned SDA_DELAY = 4;

	logic [0:42]                frame;
	i2c_bus_pkg::slot_t         slot;
	i2c_bus_pkg::slot_t         last_slot;
	logic                       busy;
	logic                       rd;
	logic                       scl_rel;
	logic [SDA_DELAY-1:0]       sdo;
	logic                       sdo_next;
	logic [1:0]                 sda_sync;
	logic [7:0]                 rdata;
	logic                       ack;
	logic                       ack_slot;
	logic                       data_slot;

	assign last_slot = rd ? i2c_bus_pkg::RD_FRAME_LAST : i2c_bus_pkg::WR_FRAME_LAST;

	assign ack_slot = (slot == i2c_bus_pkg::ADDR_ACK_SLOT) ||
		(slot == i2c_bus_pkg::SUB_ACK_SLOT) ||
		(!rd && slot == i2c_bus_pkg::WR_DATA_ACK_SLOT) ||
		(rd && slot == i2c_bus_pkg::RD_ADDR_ACK_SLOT);

	assign data_slot = rd && slot >= i2c_bus_pkg::RD_DATA_FIRST &&
		slot < i2c_bus_pkg::RD_DATA_FIRST + 6'd8;

	// new bit enters after the falling edge, the delay line lets SCL settle low first.
	assign sdo_next = (busy && bus_fall) ? frame[slot] : sdo[0];

	always_ff @(posedge CLK) begin
		sda_sync <= {sda_sync[0], sda_in};
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			slot    <= '0;
			scl_rel <= 1'b1;
			sdo     <= '1;
		end else begin
			sdo <= {sdo[SDA_DELAY-2:0], sdo_next};
			if (xfer.start) begin
				busy    <= 1'b1;
				slot    <= '0;
				scl_rel <= 1'b1;
				sdo     <= '1;
			end else if (busy && bus_rise) begin
				slot <= slot + 6'd1;
				case (slot)
					i2c_bus_pkg::START_SLOT: scl_rel <= 1'b0;
					// SCL held high across the repeated start.
					i2c_bus_pkg::RD_REPSTART_SLOT: if (rd) scl_rel <= 1'b1;
					i2c_bus_pkg::RD_REPSTART_SLOT + 6'd1: if (rd) scl_rel <= 1'b0;
					i2c_bus_pkg::WR_STOP_SLOT: if (!rd) scl_rel <= 1'b1;
					i2c_bus_pkg::RD_STOP_SLOT: if (rd) scl_rel <= 1'b1;
					default: ;
				endcase
				if (slot == last_slot) begin
					busy    <= 1'b0;
					scl_rel <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (xfer.start) begin
			rd    <= (xfer.cmd.op == i2c_bus_pkg::I2C_RD);
			ack   <= 1'b1;
			rdata <= '0;
			if (xfer.cmd.op == i2c_bus_pkg::I2C_RD) begin
				frame <= {2'b10, xfer.cmd.addr, 1'b0, 1'b1, xfer.cmd.subaddr, 3'b110,
					xfer.cmd.addr, 1'b1, 1'b1, 8'hFF, 4'b1011};
			end else begin
				frame <= {2'b10, xfer.cmd.addr, 1'b0, 1'b1, xfer.cmd.subaddr, 1'b1,
					xfer.cmd.wdata, 4'b1011, 11'h7FF};
			end
		end else if (busy && bus_rise) begin
			if (ack_slot) ack <= ack & ~sda_sync[1];
			if (data_slot) rdata <= {rdata[6:0], sda_sync[1]};
		end
	end

	assign scl_oe = ~(scl_rel | bus_clk);
	assign sda_oe = ~sdo[SDA_DELAY-1];

	assign xfer.busy = busy;
	assign xfer.rsp  = '{rdata: rdata, ack: ack};

	// the dispatcher waits for the sequencer to go idle.
	a_start_idle: assert property (@(posedge CLK) disable iff (!rst_n)
		xfer.start |-> !busy);

	// SDA moves under a high SCL only where SCL is held released on purpose.
	a_sda_stable: assert property (@(posedge CLK) disable iff (!rst_n)
		$changed(sda_oe) && !scl_oe |-> scl_rel);

	a_scl_follow: assert property (@(posedge CLK) disable iff (!rst_n)
		scl_oe |-> !scl_in);

endmodule

// File: verilog/i2c_dispatch.sv
// dispatcher moving commands to the sequencer and responses to the queue.
module i2c_dispatch (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  i2c_req_pkg::i2c_cmd_t cmd_head,
	input  logic                  cmd_empty,
	output logic                  cmd_pop,
	input  logic                  rsp_full,
	output logic                  rsp_push,
	output i2c_req_pkg::i2c_rsp_t rsp_data,
	i2c_xfer_if.ctrl              xfer
);
	logic in_flight;
	logic busy_q;
	logic busy_fell;
	logic issue;

	// one transfer outstanding until its response is queued.
	assign issue     = !in_flight && !cmd_empty && !rsp_full;
	assign busy_fell = busy_q && !xfer.busy;

	assign cmd_pop    = issue;
	assign xfer.start = issue;
	assign xfer.cmd   = cmd_head;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			in_flight <= 1'b0;
			busy_q    <= 1'b0;
			rsp_push  <= 1'b0;
		end else begin
			busy_q   <= xfer.busy;
			rsp_push <= busy_fell;
			if (issue) in_flight <= 1'b1;
			else if (rsp_push) in_flight <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (busy_fell) rsp_data <= xfer.rsp;
	end

	a_rsp_room: assert property (@(posedge CLK) disable iff (!rst_n)
		rsp_push |-> !rsp_full);

endmodule

// File: verilog/sync_fifo.sv
// synchronous FIFO with a type parameter for its payload.
module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic     CLK,
	input  logic     rst_n,
	input  logic     push,
	input  payload_t din,
	output logic     full,
	input  logic     pop,
	output payload_t dout,
	output logic     empty
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t      mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic [CW-1:0] count_next;

	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
		return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_comb begin
		case ({push, pop})
			2'b10:   count_next = count + 1'b1;
			2'b01:   count_next = count - 1'b1;
			default: count_next = count;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			empty  <= 1'b1;
			full   <= 1'b0;
		end else begin
			if (push) wr_ptr <= next_ptr(wr_ptr);
			if (pop) rd_ptr <= next_ptr(rd_ptr);
			count <= count_next;
			empty <= (count_next == '0);
			full  <= (count_next == CW'(DEPTH));
		end
	end

	always_ff @(posedge CLK) begin
		if (push) mem[wr_ptr] <= din;
	end

	// head is read combinationally.
	assign dout = mem[rd_ptr];

	a_no_overflow: assert property (@(posedge CLK) disable iff (!rst_n) push |-> !full);
	a_no_underflow: assert property (@(posedge CLK) disable iff (!rst_n) pop |-> !empty);

endmodule

// File: verilog/i2c_ctrl_top.sv
// top level joining queues, dispatcher, clock divider and bit sequencer.
`include "i2c_defs.svh"

module i2c_ctrl_top (
	input  logic       CLK,
	input  logic       rst_n,
	input  logic       cmd_push,
	input  logic       cmd_op,
	input  logic [6:0] cmd_addr,
	input  logic [7:0] cmd_subaddr,
	input  logic [7:0] cmd_wdata,
	output logic       cmd_full,
	input  logic       rsp_pop,
	output logic       rsp_empty,
	output logic [7:0] rsp_rdata,
	output logic       rsp_ack,
	output logic       scl_oe,
	output logic       sda_oe,
	input  logic       scl_in,
	input  logic       sda_in
);
	i2c_req_pkg::i2c_cmd_t cmd_in;
	i2c_req_pkg::i2c_cmd_t cmd_head;
	i2c_req_pkg::i2c_rsp_t rsp_in;
	i2c_req_pkg::i2c_rsp_t rsp_head;
	logic                  cmd_empty;
	logic                  cmd_pop;
	logic                  rsp_full;
	logic                  rsp_push;
	logic                  bus_clk;
	logic                  bus_rise;
	logic                  bus_fall;

	assign cmd_in = '{op: i2c_bus_pkg::i2c_op_e'(cmd_op), addr: cmd_addr,
		subaddr: cmd_subaddr, wdata: cmd_wdata};

	assign rsp_rdata = rsp_head.rdata;
	assign rsp_ack   = rsp_head.ack;

	i2c_xfer_if i_xfer ();

	sync_fifo #(.payload_t(i2c_req_pkg::i2c_cmd_t), .DEPTH(`I2C_QUEUE_DEPTH)) i_cmd_fifo (
		.CLK(CLK), .rst_n(rst_n), .push(cmd_push), .din(cmd_in), .full(cmd_full),
		.pop(cmd_pop), .dout(cmd_head), .empty(cmd_empty));

	sync_fifo #(.payload_t(i2c_req_pkg::i2c_rsp_t), .DEPTH(`I2C_QUEUE_DEPTH)) i_rsp_fifo (
		.CLK(CLK), .rst_n(rst_n), .push(rsp_push), .din(rsp_in), .full(rsp_full),
		.pop(rsp_pop), .dout(rsp_head), .empty(rsp_empty));

	i2c_dispatch i_dispatch (
		.CLK(CLK), .rst_n(rst_n), .cmd_head(cmd_head), .cmd_empty(cmd_empty),
		.cmd_pop(cmd_pop), .rsp_full(rsp_full), .rsp_push(rsp_push),
		.rsp_data(rsp_in), .xfer(i_xfer.ctrl));

	i2c_clock_gen i_clock_gen (
		.CLK(CLK), .rst_n(rst_n), .bus_clk(bus_clk), .bus_rise(bus_rise),
		.bus_fall(bus_fall));

	i2c_master i_master (
		.CLK(CLK), .rst_n(rst_n), .bus_clk(bus_clk), .bus_rise(bus_rise),
		.bus_fall(bus_fall), .xfer(i_xfer.seq), .scl_oe(scl_oe), .sda_oe(sda_oe),
		.scl_in(scl_in), .sda_in(sda_in));

endmodule

// File: testbench/tb_clock_gen.sv
// free running testbench clock with a period of ten time units.
module tb_clock_gen (
	output logic CLK
);
	initial begin
		CLK = 1'b0;
	end

	always #5 CLK = ~CLK;

endmodule

// File: testbench/i2c_slave_model.sv
// behavioral I2C target with a 256-byte register file and a bus protocol monitor.
module i2c_slave_model #(
	parameter logic [6:0] ADDR = 7'h3a
) (
	input  logic CLK,
	input  logic rst_n,
	input  logic scl,
	input  logic sda,
	output logic sda_oe
);
	typedef enum logic [2:0] {S_IDLE, S_RX, S_ACK, S_TX, S_MACK, S_SKIP} state_e;

	logic [7:0] regs [256];
	logic [7:0] shreg;
	logic [7:0] ptr;
	logic       scl_q;
	logic       sda_q;
	logic       selected;
	logic       rd;
	logic       in_xfer;
	logic       rep_pending;
	int         bit_cnt;
	int         byte_idx;
	state_e     state;
	int         start_cnt;
	int         rep_cnt;
	int         stop_cnt;
	int         violations;

	always @(posedge CLK) begin
		if (!rst_n) begin
			for (int i = 0; i < 256; i++) regs[i] = 8'(i);
			scl_q = 1'b1;
			sda_q = 1'b1;
			in_xfer = 1'b0;
			rep_pending = 1'b0;
			selected = 1'b0;
			rd = 1'b0;
			state = S_IDLE;
			start_cnt = 0;
			rep_cnt = 0;
			stop_cnt = 0;
			violations = 0;
			sda_oe <= 1'b0;
		end else begin
			if (scl_q && scl && sda_q && !sda) begin
				if (state == S_ACK || state == S_TX) begin
					violations++;
					$display("protocol error: start at time %0t while the target drives SDA", $time);
				end
				// a start inside a transfer only counts once a bit is clocked after it.
				if (!in_xfer) begin
					start_cnt++;
					in_xfer = 1'b1;
				end else begin
					rep_pending = 1'b1;
				end
				state = S_RX;
				bit_cnt = 0;
				byte_idx = 0;
				sda_oe <= 1'b0;
			end else if (scl_q && scl && !sda_q && sda) begin
				if (!in_xfer || state == S_ACK || state == S_TX) begin
					violations++;
					$display("protocol error: stop at time %0t outside a transfer frame", $time);
				end else begin
					stop_cnt++;
				end
				in_xfer = 1'b0;
				rep_pending = 1'b0;
				state = S_IDLE;
				sda_oe <= 1'b0;
			end else if (!scl_q && scl) begin
				if (rep_pending) begin
					rep_cnt++;
					rep_pending = 1'b0;
				end
				if (state == S_RX) shreg = {shreg[6:0], sda};
				if (state == S_RX || state == S_TX) bit_cnt++;
			end else if (scl_q && !scl) begin
				case (state)
					S_RX: if (bit_cnt == 8) begin
						if (byte_idx == 0) begin
							selected = (shreg[7:1] == ADDR);
							rd = shreg[0];
						end else if (selected && byte_idx == 1) begin
							ptr = shreg;
						end else if (selected && !rd) begin
							regs[ptr] = shreg;
						end
						byte_idx++;
						bit_cnt = 0;
						state = selected ? S_ACK : S_SKIP;
						sda_oe <= selected;
					end
					S_ACK: if (rd) begin
						state = S_TX;
						bit_cnt = 0;
						sda_oe <= !regs[ptr][7];
					end else begin
						state = S_RX;
						sda_oe <= 1'b0;
					end
					S_TX: if (bit_cnt < 8) begin
						sda_oe <= !regs[ptr][3'(7 - bit_cnt)];
					end else begin
						state = S_MACK;
						sda_oe <= 1'b0;
					end
					S_MACK: state = S_SKIP;
					default: ;
				endcase
			end
			scl_q = scl;
			sda_q = sda;
		end
	end

endmodule

// File: testbench/tb_i2c_ctrl.sv
// testbench top with the stimulus table, value check, watchdog and reporting.
module tb_i2c_ctrl;
	localparam int         NUM_ROWS   = 12;
	localparam int         CLK_PERIOD = 10;
	localparam logic [6:0] SLAVE_ADDR = 7'h3a;

	logic       CLK;
	logic       rst_n;
	logic       cmd_push;
	logic       cmd_op;
	logic [6:0] cmd_addr;
	logic [7:0] cmd_subaddr;
	logic [7:0] cmd_wdata;
	logic       cmd_full;
	logic       rsp_pop;
	logic       rsp_empty;
	logic [7:0] rsp_rdata;
	logic       rsp_ack;
	logic       scl_oe;
	logic       sda_oe;
	logic       slave_sda_oe;
	logic       scl_line;
	logic       sda_line;

	// stimulus table, one row per command.
	logic       row_op    [NUM_ROWS];
	logic [6:0] row_addr  [NUM_ROWS];
	logic [7:0] row_sub   [NUM_ROWS];
	logic [7:0] row_wdata [NUM_ROWS];
	logic [7:0] row_rdata [NUM_ROWS];
	logic       row_ack   [NUM_ROWS];
	logic       row_burst [NUM_ROWS];
	logic [7:0] shadow    [256];
	int         num_rows;
	int         num_reads;
	int         rsp_done;
	int         errors;
	int         rows_failed;

	// open-drain lines resolve as a wired-AND.
	assign scl_line = !scl_oe;
	assign sda_line = !(sda_oe || slave_sda_oe);

	tb_clock_gen i_clk (.CLK(CLK));

	i2c_ctrl_top i_dut (
		.CLK(CLK), .rst_n(rst_n), .cmd_push(cmd_push), .cmd_op(cmd_op),
		.cmd_addr(cmd_addr), .cmd_subaddr(cmd_subaddr), .cmd_wdata(cmd_wdata),
		.cmd_full(cmd_full), .rsp_pop(rsp_pop), .rsp_empty(rsp_empty),
		.rsp_rdata(rsp_rdata), .rsp_ack(rsp_ack), .scl_oe(scl_oe), .sda_oe(sda_oe),
		.scl_in(scl_line), .sda_in(sda_line));

	i2c_slave_model #(.ADDR(SLAVE_ADDR)) i_slave (
		.CLK(CLK), .rst_n(rst_n), .scl(scl_line), .sda(sda_line), .sda_oe(slave_sda_oe));

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at time %0t: %s, expected %0h, got %0h", $time, msg,
				expected, actual);
		end
	endtask

	// expected values follow the shadow register file of the target.
	task automatic add_row(input logic op, input logic [6:0] addr, input logic [7:0] sub,
		input logic burst);
		int k;
		k = num_rows;
		row_op[k] = op;
		row_addr[k] = addr;
		row_sub[k] = sub;
		row_burst[k] = burst;
		row_wdata[k] = op ? 8'h00 : 8'($urandom());
		row_ack[k] = (addr == SLAVE_ADDR);
		if (!op && addr == SLAVE_ADDR) shadow[sub] = row_wdata[k];
		row_rdata[k] = (addr == SLAVE_ADDR) ? shadow[sub] : 8'hFF;
		if (op) num_reads++;
		num_rows++;
	endtask

	initial begin
		#((NUM_ROWS * 1000 + 10) * CLK_PERIOD);
		$display("run timed out before all responses arrived");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int e0;
		void'($urandom(32'h126c));
		rst_n = 1'b0;
		cmd_push = 1'b0;
		cmd_op = 1'b0;
		cmd_addr = '0;
		cmd_subaddr = '0;
		cmd_wdata = '0;
		rsp_pop = 1'b0;
		num_rows = 0;
		num_reads = 0;
		rsp_done = 0;
		errors = 0;
		rows_failed = 0;
		for (int i = 0; i < 256; i++) shadow[i] = 8'(i);

		add_row(1'b0, SLAVE_ADDR, 8'h10, 1'b0);
		add_row(1'b1, SLAVE_ADDR, 8'h10, 1'b0);
		add_row(1'b1, SLAVE_ADDR, 8'h55, 1'b0);
		add_row(1'b0, 7'h21, 8'h20, 1'b0);
		add_row(1'b1, 7'h21, 8'h10, 1'b0);
		add_row(1'b1, SLAVE_ADDR, 8'h20, 1'b0);
		// six back to back commands overrun the four-entry command queue.
		add_row(1'b0, SLAVE_ADDR, 8'h30, 1'b1);
		add_row(1'b0, SLAVE_ADDR, 8'h31, 1'b1);
		add_row(1'b1, SLAVE_ADDR, 8'h30, 1'b1);
		add_row(1'b1, SLAVE_ADDR, 8'h31, 1'b1);
		add_row(1'b0, SLAVE_ADDR, 8'h30, 1'b1);
		add_row(1'b1, SLAVE_ADDR, 8'h30, 1'b1);

		repeat (10) @(posedge CLK);
		rst_n <= 1'b1;
		@(negedge CLK);
		check_value(scl_oe, 1'b0, "scl_oe after reset");
		check_value(sda_oe, 1'b0, "sda_oe after reset");
		check_value(rsp_empty, 1'b1, "rsp_empty after reset");
		check_value(cmd_full, 1'b0, "cmd_full after reset");

		fork
			begin
				for (int i = 0; i < num_rows; i++) begin
					if (!row_burst[i]) begin
						while (rsp_done < i) @(negedge CLK);
					end
					while (cmd_full) @(negedge CLK);
					@(posedge CLK);
					cmd_push <= 1'b1;
					cmd_op <= row_op[i];
					cmd_addr <= row_addr[i];
					cmd_subaddr <= row_sub[i];
					cmd_wdata <= row_wdata[i];
					@(posedge CLK);
					cmd_push <= 1'b0;
					@(negedge CLK);
				end
			end
			begin
				for (int j = 0; j < num_rows; j++) begin
					e0 = errors;
					while (rsp_empty) @(negedge CLK);
					check_value(rsp_ack, row_ack[j], $sformatf("row %0d ack", j));
					if (row_op[j]) begin
						check_value(rsp_rdata, row_rdata[j], $sformatf("row %0d rdata", j));
					end
					if (errors != e0) rows_failed++;
					$display("row %0d %s addr %h sub %h: rdata %h ack %b %s", j,
						row_op[j] ? "read " : "write", row_addr[j], row_sub[j], rsp_rdata,
						rsp_ack, (errors == e0) ? "ok" : "FAIL");
					@(posedge CLK);
					rsp_pop <= 1'b1;
					@(posedge CLK);
					rsp_pop <= 1'b0;
					rsp_done++;
					@(negedge CLK);
				end
			end
		join

		// one response per command, nothing left behind.
		check_value(rsp_empty, 1'b1, "response queue empty after the last row");
		check_value(i_slave.start_cnt, num_rows, "start conditions seen by the target");
		check_value(i_slave.stop_cnt, num_rows, "stop conditions seen by the target");
		check_value(i_slave.rep_cnt, num_reads, "repeated starts seen by the target");
		check_value(i_slave.violations, 0, "bus protocol violations");

		$display("rows %0d, passed %0d, failed %0d, errors %0d", num_rows,
			num_rows - rows_failed, rows_failed, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+verilog
verilog/i2c_bus_pkg.sv
verilog/i2c_req_pkg.sv
verilog/i2c_xfer_if.sv
verilog/i2c_clock_gen.sv
verilog/i2c_master.sv
verilog/i2c_dispatch.sv
verilog/sync_fifo.sv
verilog/i2c_ctrl_top.sv
testbench/tb_clock_gen.sv
testbench/i2c_slave_model.sv
testbench/tb_i2c_ctrl.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the I2C controller testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_i2c_ctrl
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_i2c_ctrl)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
	exit 0
else
	exit 1
fi
